/* hdl/hsst_frame_sequencer.sv */
// Frame sequencer that steps the word position through the 32-byte test frame
`timescale 1ns/1ps
`default_nettype none

module hsst_frame_sequencer
    import hsst_pattern_pkg::*;
#(
    parameter int LANE_BYTES = 4
) (
    input  wire        src_clk,
    input  wire        i_src_rstn,
    output slot_t      o_slot,
    output logic [1:0] o_group_pos,
    output logic       o_payload_adv
);

    localparam int WORDS  = FRAME_BYTES / LANE_BYTES;
    localparam int CNT_W  = $clog2(WORDS);
    localparam int BYTE_W = $clog2(FRAME_BYTES);
    localparam int POS_W  = $clog2(GROUP_BYTES);
    localparam int GRP_W  = $clog2(GROUPS_PER_FRAME);

    localparam logic [CNT_W-1:0] LAST_WORD     = CNT_W'(WORDS - 1);
    localparam logic [GRP_W-1:0] SKIP_GROUP    = GRP_W'(GROUPS_PER_FRAME - 2);
    localparam logic [GRP_W-1:0] PAYLOAD_GROUP = GRP_W'(GROUPS_PER_FRAME - 1);

    logic [CNT_W-1:0]  word_cnt;
    logic [BYTE_W-1:0] frame_byte;
    logic [GRP_W-1:0]  group;

    //////////////////////////////////////////////////
    // Word counter
    //////////////////////////////////////////////////

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            word_cnt <= '0;
        end else if (word_cnt == LAST_WORD) begin
            word_cnt <= '0;
        end else begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Position decode
    //////////////////////////////////////////////////

    // Byte offset of lane byte 0 within the frame
    assign frame_byte  = BYTE_W'(word_cnt * LANE_BYTES);
    assign group       = frame_byte[BYTE_W-1:POS_W];
    assign o_group_pos = frame_byte[POS_W-1:0];

    always_comb begin
        case (group)
            '0:            o_slot = SLOT_ALIGN;
            SKIP_GROUP:    o_slot = SLOT_SKIP;
            PAYLOAD_GROUP: o_slot = SLOT_PAYLOAD;
            default:       o_slot = SLOT_IDLE;
        endcase
    end

    // Payload register steps once per payload word
    assign o_payload_adv = (o_slot == SLOT_PAYLOAD);

endmodule

`default_nettype wire

/* hdl/hsst_pattern_pkg.sv */
// HSST pattern package with 8B10B character codes, frame geometry and lane configuration types
`default_nettype none

package hsst_pattern_pkg;

    //////////////////////////////////////////////////
    // 8B10B symbols
    //////////////////////////////////////////////////

    // Control flag on top of the data byte, as the PCS sees it on TXK/TXD
    typedef struct packed {
        logic       k;
        logic [7:0] data;
    } sym_t;

    // Comma characters selectable by the receive comma register
    localparam sym_t K28_5 = '{k: 1'b1, data: 8'hBC};
    localparam sym_t K28_1 = '{k: 1'b1, data: 8'h3C};
    localparam sym_t K28_7 = '{k: 1'b1, data: 8'hFC};

    // Channel bonding /A/ character
    localparam sym_t K28_3_A = '{k: 1'b1, data: 8'h7C};

    // Data characters of the idle and GE skip ordered sets
    localparam sym_t D5_6  = '{k: 1'b0, data: 8'hC5};
    localparam sym_t D16_2 = '{k: 1'b0, data: 8'h50};

    //////////////////////////////////////////////////
    // Frame geometry
    //////////////////////////////////////////////////

    // Eight groups of four bytes: align, 5x idle, skip, payload
    localparam int FRAME_BYTES      = 32;
    localparam int GROUP_BYTES      = 4;
    localparam int GROUPS_PER_FRAME = FRAME_BYTES / GROUP_BYTES;

    typedef enum logic [1:0] {
        SLOT_ALIGN,
        SLOT_IDLE,
        SLOT_SKIP,
        SLOT_PAYLOAD
    } slot_t;

    //////////////////////////////////////////////////
    // Receive side configuration
    //////////////////////////////////////////////////

    // Code 3 is not defined and falls back to K28.5
    typedef enum logic [1:0] {
        COMMA_K28_5 = 2'd0,
        COMMA_K28_1 = 2'd1,
        COMMA_K28_7 = 2'd2
    } comma_sel_t;

    typedef enum logic {
        SKIP_BYPASS = 1'b0,
        SKIP_GE     = 1'b1
    } skip_mode_t;

    // Comma symbol for a comma select code
    function automatic sym_t comma_sym(input comma_sel_t sel);
        case (sel)
            COMMA_K28_1: comma_sym = K28_1;
            COMMA_K28_7: comma_sym = K28_7;
            default:     comma_sym = K28_5;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/hsst_pattern_src.sv */
// HSST transmit test pattern source, one 8B10B lane of align/idle/skip/payload frames
`timescale 1ns/1ps
`default_nettype none

module hsst_pattern_src
    import hsst_pattern_pkg::*;
#(
    parameter int LANE_BYTES = 4
) (
    input  wire                       src_clk,
    input  wire                       i_src_rstn,
    input  wire comma_sel_t           i_comma_sel,
    input  wire                       i_bond_en,
    input  wire skip_mode_t           i_skip_mode,
    output logic [LANE_BYTES*8-1:0]   o_txd,
    output logic [LANE_BYTES-1:0]     o_txk
);

    slot_t                   slot;
    logic [1:0]              group_pos;
    logic                    payload_adv;
    logic [LANE_BYTES*8-1:0] payload;

    // Fabric widths of the 8B10B modes
    if (!(LANE_BYTES == 1 || LANE_BYTES == 2 || LANE_BYTES == 4)) begin : g_width_check
        $error("LANE_BYTES must be 1, 2 or 4");
    end

    //////////////////////////////////////////////////
    // Producer
    //////////////////////////////////////////////////

    hsst_frame_sequencer #(
        .LANE_BYTES    (LANE_BYTES)
    ) u_sequencer (
        .src_clk       (src_clk),
        .i_src_rstn    (i_src_rstn),
        .o_slot        (slot),
        .o_group_pos   (group_pos),
        .o_payload_adv (payload_adv)
    );

    hsst_payload_gen #(
        .LANE_BYTES    (LANE_BYTES)
    ) u_payload_gen (
        .src_clk       (src_clk),
        .i_src_rstn    (i_src_rstn),
        .i_payload_adv (payload_adv),
        .o_payload     (payload)
    );

    //////////////////////////////////////////////////
    // Consumer
    //////////////////////////////////////////////////

    hsst_symbol_mapper #(
        .LANE_BYTES    (LANE_BYTES)
    ) u_mapper (
        .src_clk       (src_clk),
        .i_src_rstn    (i_src_rstn),
        .i_slot        (slot),
        .i_group_pos   (group_pos),
        .i_payload     (payload),
        .i_comma_sel   (i_comma_sel),
        .i_bond_en     (i_bond_en),
        .i_skip_mode   (i_skip_mode),
        .o_txd         (o_txd),
        .o_txk         (o_txk)
    );

endmodule

`default_nettype wire

/* hdl/hsst_payload_gen.sv */
// Payload generator, a lane-wide walking one that steps on every payload word
`timescale 1ns/1ps
`default_nettype none

module hsst_payload_gen #(
    parameter int LANE_BYTES = 4
) (
    input  wire                       src_clk,
    input  wire                       i_src_rstn,
    input  wire                       i_payload_adv,
    output logic [LANE_BYTES*8-1:0]   o_payload
);

    localparam int W = LANE_BYTES * 8;

    //////////////////////////////////////////////////
    // Walking one
    //////////////////////////////////////////////////

    // The mapper registers the value ahead of the rotate on the same edge,
    // so the first payload word after reset carries bit 0
    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            o_payload <= W'(1);
        end else if (i_payload_adv) begin
            o_payload <= {o_payload[W-2:0], o_payload[W-1]};
        end
    end

    a_payload_onehot: assert property (
        @(posedge src_clk) disable iff (!i_src_rstn)
        $onehot(o_payload)
    ) else $error("payload pattern lost its single set bit");

endmodule

`default_nettype wire

/* hdl/hsst_symbol_mapper.sv */
// Symbol mapper, turns slot and position into registered TXD/TXK lane words
`timescale 1ns/1ps
`default_nettype none

module hsst_symbol_mapper
    import hsst_pattern_pkg::*;
#(
    parameter int LANE_BYTES = 4
) (
    input  wire                       src_clk,
    input  wire                       i_src_rstn,
    input  wire slot_t                i_slot,
    input  wire [1:0]                 i_group_pos,
    input  wire [LANE_BYTES*8-1:0]    i_payload,
    input  wire comma_sel_t           i_comma_sel,
    input  wire                       i_bond_en,
    input  wire skip_mode_t           i_skip_mode,
    output logic [LANE_BYTES*8-1:0]   o_txd,
    output logic [LANE_BYTES-1:0]     o_txk
);

    sym_t                    comma;
    sym_t                    idle_tbl  [GROUP_BYTES];
    sym_t                    align_tbl [GROUP_BYTES];
    sym_t                    skip_tbl  [GROUP_BYTES];
    logic [LANE_BYTES*8-1:0] next_txd;
    logic [LANE_BYTES-1:0]   next_txk;

    //////////////////////////////////////////////////
    // Group tables
    //////////////////////////////////////////////////

    assign comma = comma_sym(i_comma_sel);

    // Idle ordered set alternates comma and D5.6
    always_comb begin
        for (int i = 0; i < GROUP_BYTES; i++) begin
            idle_tbl[i] = (i % 2 == 0) ? comma : D5_6;
        end
    end

    // /A/ replaces the first comma only when bonding is on
    always_comb begin
        for (int i = 0; i < GROUP_BYTES; i++) begin
            if (i == 0 && i_bond_en) begin
                align_tbl[i] = K28_3_A;
            end else begin
                align_tbl[i] = idle_tbl[i];
            end
        end
    end

    // GE clock correction uses K28.5/D16.2 pairs, fixed comma
    always_comb begin
        for (int i = 0; i < GROUP_BYTES; i++) begin
            if (i_skip_mode == SKIP_GE) begin
                skip_tbl[i] = (i % 2 == 0) ? K28_5 : D16_2;
            end else begin
                skip_tbl[i] = idle_tbl[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // Lane byte select
    //////////////////////////////////////////////////

    for (genvar j = 0; j < LANE_BYTES; j++) begin : g_lane
        logic [1:0] byte_idx;
        sym_t       sym;

        // Lane byte j sits j bytes further into the group
        assign byte_idx = i_group_pos + 2'(j);

        always_comb begin
            case (i_slot)
                SLOT_ALIGN:   sym = align_tbl[byte_idx];
                SLOT_SKIP:    sym = skip_tbl[byte_idx];
                SLOT_PAYLOAD: sym = '{k: 1'b0, data: i_payload[j*8 +: 8]};
                default:      sym = idle_tbl[byte_idx];
            endcase
        end

        assign next_txd[j*8 +: 8] = sym.data;
        assign next_txk[j]        = sym.k;
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge src_clk) begin
        if (!i_src_rstn) begin
            o_txd <= '0;
            o_txk <= '0;
        end else begin
            o_txd <= next_txd;
            o_txk <= next_txk;
        end
    end

    // A payload word never carries a control character
    a_payload_no_k: assert property (
        @(posedge src_clk) disable iff (!i_src_rstn)
        (i_slot == SLOT_PAYLOAD) |=> (o_txk == '0)
    ) else $error("control flag set on payload word");

    // Configuration is static once the lane is out of reset
    a_cfg_static: assert property (
        @(posedge src_clk) disable iff (!i_src_rstn)
        $past(i_src_rstn) |->
            ($stable(i_comma_sel) && $stable(i_bond_en) && $stable(i_skip_mode))
    ) else $error("lane configuration changed outside reset");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the pattern source testbench for every lane width with Verilator

LOG=sim.log
rm -f "$LOG"

for lb in 1 2 4; do
    echo "=== LANE_BYTES=$lb ===" >> "$LOG"
    verilator --binary --timing --assert \
        -f sources.f \
        --top-module tb_hsst_pattern_src \
        -GLANE_BYTES=$lb \
        -Mdir "obj_dir_lb$lb" \
        -o "sim_lb$lb" >> "$LOG" 2>&1 &&
    "./obj_dir_lb$lb/sim_lb$lb" >> "$LOG" 2>&1 ||
    echo "*** FAILED ***" >> "$LOG"
done

grep -qF '*** FAILED ***' "$LOG" && echo "Simulation failed, see $LOG" && exit 1

echo "All lane widths passed, see $LOG"
exit 0

/* sources.f */
+incdir+testbench
hdl/hsst_pattern_pkg.sv
hdl/hsst_frame_sequencer.sv
hdl/hsst_payload_gen.sv
hdl/hsst_symbol_mapper.sv
hdl/hsst_pattern_src.sv
testbench/tb_hsst_pattern_src.sv

/* testbench/tb_pattern_model.svh */
// Reference model of the test frame, expected lane words from the group byte rules
`ifndef TB_PATTERN_MODEL_SVH
`define TB_PATTERN_MODEL_SVH

// Comma for a select code, unused code 3 means K28.5
function automatic sym_t comma_for_sel(input logic [1:0] sel);
    case (sel)
        2'd1:    return K28_1;
        2'd2:    return K28_7;
        default: return K28_5;
    endcase
endfunction

// Byte pos of group grp, for every group except the payload group
function automatic sym_t group_byte(input int grp, input int pos, input logic [1:0] sel,
                                    input logic bond, input logic skip_ge);
    sym_t comma;
    sym_t idle;
    comma = comma_for_sel(sel);
    idle  = (pos % 2 == 0) ? comma : D5_6;
    if (grp == 0 && pos == 0 && bond) begin
        return K28_3_A;
    end
    if (grp == GROUPS_PER_FRAME - 2 && skip_ge) begin
        return (pos % 2 == 0) ? K28_5 : D16_2;
    end
    return idle;
endfunction

// Whole lane word w of the frame, lane byte 0 in the low bits
function automatic void expected_word(input int w, input logic [LANE_BYTES*8-1:0] payload,
                                      input logic [1:0] sel, input logic bond,
                                      input logic skip_ge,
                                      output logic [LANE_BYTES*8-1:0] txd,
                                      output logic [LANE_BYTES-1:0] txk);
    int   addr;
    int   grp;
    sym_t sym;
    for (int j = 0; j < LANE_BYTES; j++) begin
        addr = w * LANE_BYTES + j;
        grp  = addr / GROUP_BYTES;
        if (grp == GROUPS_PER_FRAME - 1) begin
            txd[j*8 +: 8] = payload[j*8 +: 8];
            txk[j]        = 1'b0;
        end else begin
            sym           = group_byte(grp, addr % GROUP_BYTES, sel, bond, skip_ge);
            txd[j*8 +: 8] = sym.data;
            txk[j]        = sym.k;
        end
    end
endfunction

// Next walking one value
function automatic logic [LANE_BYTES*8-1:0] walk_one(input logic [LANE_BYTES*8-1:0] p);
    return {p[LANE_BYTES*8-2:0], p[LANE_BYTES*8-1]};
endfunction

`endif

/* testbench/tb_hsst_pattern_src.sv */
// Testbench for the HSST pattern source, checks every lane word against a frame model
`timescale 1ns/1ps
`default_nettype none

module tb_hsst_pattern_src
    import hsst_pattern_pkg::*;
#(
    parameter int LANE_BYTES = 4
);

    localparam int W          = LANE_BYTES * 8;
    localparam int WORDS      = FRAME_BYTES / LANE_BYTES;
    localparam int CLK_NS     = 4;
    localparam int RST_CYCLES = 16;
    localparam int FIXED_ROWS = 6;
    localparam int RAND_ROWS  = 3;
    localparam int ROWS       = FIXED_ROWS + RAND_ROWS;

    typedef struct {
        string      name;
        logic [1:0] comma;
        logic       bond;
        logic       skip_ge;
        int         frames;
    } row_t;

    logic                  src_clk;
    logic                  i_src_rstn;
    comma_sel_t            i_comma_sel;
    logic                  i_bond_en;
    skip_mode_t            i_skip_mode;
    logic [W-1:0]          o_txd;
    logic [LANE_BYTES-1:0] o_txk;

    row_t        rows [ROWS];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    bit          table_ready;

    `include "tb_pattern_model.svh"

    hsst_pattern_src #(
        .LANE_BYTES  (LANE_BYTES)
    ) uut (
        .src_clk     (src_clk),
        .i_src_rstn  (i_src_rstn),
        .i_comma_sel (i_comma_sel),
        .i_bond_en   (i_bond_en),
        .i_skip_mode (i_skip_mode),
        .o_txd       (o_txd),
        .o_txk       (o_txk)
    );

    initial begin
        src_clk = 1'b0;
        forever #(CLK_NS / 2) src_clk = ~src_clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h at %0t",
                     test, what, expected, actual, $time);
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic [1:0] comma,
                           input logic bond, input logic skip_ge, input int frames);
        rows[idx].name    = name;
        rows[idx].comma   = comma;
        rows[idx].bond    = bond;
        rows[idx].skip_ge = skip_ge;
        rows[idx].frames  = frames;
    endtask

    // Every comma, bonding on and off, both skip modes, then random rows
    task automatic fill_table();
        set_row(0, "k28_5_plain",   2'd0, 1'b0, 1'b0, 3);
        set_row(1, "k28_1_bond",    2'd1, 1'b1, 1'b0, 3);
        set_row(2, "k28_7_ge",      2'd2, 1'b0, 1'b1, 3);
        set_row(3, "k28_5_bond_ge", 2'd0, 1'b1, 1'b1, 34);
        set_row(4, "comma3_plain",  2'd3, 1'b0, 1'b0, 2);
        set_row(5, "k28_1_ge",      2'd1, 1'b0, 1'b1, 2);
        rng_state = 32'hadfa0b60;
        for (int i = 0; i < RAND_ROWS; i++) begin
            rng_state = xorshift32(rng_state);
            set_row(FIXED_ROWS + i, $sformatf("random_%0d", i), rng_state[1:0],
                    rng_state[2], rng_state[3], 1 + int'(rng_state[5:4]));
        end
    endtask

    task automatic run_row(input int idx);
        logic [W-1:0]          payload_model;
        logic [W-1:0]          exp_txd;
        logic [LANE_BYTES-1:0] exp_txk;
        i_src_rstn  = 1'b0;
        i_comma_sel = comma_sel_t'(rows[idx].comma);
        i_bond_en   = rows[idx].bond;
        i_skip_mode = skip_mode_t'(rows[idx].skip_ge);
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(negedge src_clk);
            check_value(rows[idx].name, "txd in reset", 64'(0), 64'(o_txd));
            check_value(rows[idx].name, "txk in reset", 64'(0), 64'(o_txk));
        end
        i_src_rstn = 1'b1;
        // No rising edge has seen the release yet
        check_value(rows[idx].name, "txd at release", 64'(0), 64'(o_txd));
        check_value(rows[idx].name, "txk at release", 64'(0), 64'(o_txk));
        payload_model = W'(1);
        for (int f = 0; f < rows[idx].frames; f++) begin
            for (int w = 0; w < WORDS; w++) begin
                @(negedge src_clk);
                expected_word(w, payload_model, rows[idx].comma, rows[idx].bond,
                              rows[idx].skip_ge, exp_txd, exp_txk);
                check_value(rows[idx].name, $sformatf("txd frame %0d word %0d", f, w),
                            64'(exp_txd), 64'(o_txd));
                check_value(rows[idx].name, $sformatf("txk frame %0d word %0d", f, w),
                            64'(exp_txk), 64'(o_txk));
                if ((w * LANE_BYTES) / GROUP_BYTES == GROUPS_PER_FRAME - 1) begin
                    payload_model = walk_one(payload_model);
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        errors      = 0;
        checks      = 0;
        i_src_rstn  = 1'b0;
        i_comma_sel = COMMA_K28_5;
        i_bond_en   = 1'b0;
        i_skip_mode = SKIP_BYPASS;
        fill_table();
        table_ready = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = 0;
        for (int r = 0; r < ROWS; r++) begin
            limit_ns += (RST_CYCLES + rows[r].frames * 32 + 4) * CLK_NS * 2;
        end
        #(limit_ns);
        $display("Watchdog timeout: no result after %0d ns", limit_ns);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
